// ==== drawSubsystem.f ====
+incdir+src
src/drawCmdPkg.sv
src/frameBufPkg.sv
src/drawCfgIf.sv
src/drawRegs.sv
src/drawSequencer.sv
src/streamFifo.sv
src/drawEngine.sv
src/drawSubsystem.sv
verification/drawSubsystemTb.sv

// ==== runSim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f drawSubsystem.f --top-module drawSubsystemTb -o drawSubsystemSim \
    || exit 1
./obj_dir/drawSubsystemSim | tee /dev/stderr | grep -q "No errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verification/drawSubsystemTb.sv ====
`include "drawConsts.svh"
`default_nettype none

module drawSubsystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCREEN_PIX = `SCREEN_W * `SCREEN_H;
    localparam int FRAME_PIX  = SCREEN_PIX + 3 * `SCREEN_W; // Clear plus three rows.
    localparam int NUM_FRAMES = 3;
    localparam int TOTAL_PIX  = 2 * SCREEN_PIX + NUM_FRAMES * FRAME_PIX;
    // About 1.4 cycles per pixel at 70% ready, the rest is margin.
    localparam int TIMEOUT_CYCLES = TOTAL_PIX * 7;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        regWrEn;
    logic [1:0]  regAddr;
    logic [31:0] regWrData;
    logic        dataUpdate;
    logic [31:0] pulseCounter;
    logic [31:0] accumCounter;
    logic        frameReq;
    logic        frameAck;
    logic        frameDone;
    logic        pixWrValid;
    logic        pixWrReady;
    logic [`FB_ADDR_W-1:0] pixWrAddr;
    logic [15:0] pixWrData;

    logic [39:0] expQ[$];     // Expected writes, {addr, data}.
    logic [39:0] expHead;
    logic [1:0]  shadowMode;  // Register values as the DUT will hold them.
    logic [15:0] shadowFg;
    logic [15:0] shadowBg;
    logic [31:0] shadowPulse;
    logic [31:0] readySeed = 32'h3a89;
    logic [31:0] ackSeed   = 32'h3a89;
    logic        powerOnSeen = 1'b0;
    int          errCount = 0;
    int          checkedCount = 0;
    int          testCount = 0;
    int          testErrBase = 0;
    int          testPixBase = 0;
    int          cycleCount = 0;

    drawSubsystem u_drawSubsystem (.*);

    always #50 clk = ~clk; // 100 ns period.

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Reference pixel model.
    task automatic expectClear(input logic [15:0] color);
        for (int a = 0; a < SCREEN_PIX; a++) expQ.push_back({24'(a), color});
    endtask

    task automatic expectBitRow(input int row, input logic [15:0] fg, input logic [15:0] bg,
                                input logic [31:0] value);
        for (int k = 0; k < `SCREEN_W; k++) begin
            expQ.push_back({24'(row * `SCREEN_W + k), value[k] ? fg : bg}); // Bit k, column k.
        end
    endtask

    task automatic expectModeRow(input int row, input logic [15:0] fg, input logic [15:0] bg,
                                 input logic [1:0] mode);
        for (int k = 0; k < `SCREEN_W; k++) begin
            expQ.push_back({24'(row * `SCREEN_W + k), (k / (`SCREEN_W / 4) == mode) ? fg : bg});
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Stimulus tasks. Called just after a rising edge.
    task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
        regWrEn   <= 1'b1;
        regAddr   <= addr;
        regWrData <= data;
        case (addr)
            2'd0:    shadowMode <= data[1:0];
            2'd1:    shadowFg   <= data[15:0];
            2'd2:    shadowBg   <= data[15:0];
            default: ;
        endcase
        @(posedge clk);
        regWrEn <= 1'b0;
    endtask

    task automatic latchPulse(input logic [31:0] value);
        pulseCounter <= value;
        dataUpdate   <= 1'b1;
        shadowPulse  <= value;
        @(posedge clk);
        dataUpdate <= 1'b0;
    endtask

    // Returns at the grant edge.
    task automatic grantFrame();
        int delay;
        while (!frameReq) @(posedge clk);
        ackSeed = lcgNext(ackSeed);
        delay   = int'((ackSeed >> 16) % 6); // Random wait before the ack.
        repeat (delay) @(posedge clk);
        frameAck <= 1'b1;
        @(posedge clk);
        frameAck <= 1'b0;
    endtask

    task automatic finishTest(input string name);
        do @(posedge clk); while (!frameDone);
        // Last pixels of the frame may still sit in the pixel queue.
        do @(negedge clk); while (expQ.size() != 0);
        @(posedge clk);
        testCount++;
        $display("Test %0d %s: %0d pixel writes checked, %0d errors", testCount, name,
                 checkedCount - testPixBase, errCount - testErrBase);
        testPixBase = checkedCount;
        testErrBase = errCount;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Monitor and immediate checks.
    always @(posedge clk) begin
        if (rst_n) begin
            if (pixWrValid && pixWrReady) begin
                checkedCount++;
                noExtraWrite: assert (expQ.size() != 0) else begin
                    errCount++;
                    $display("Pixel write accepted at addr %h with nothing expected", pixWrAddr);
                end
                if (expQ.size() != 0) begin
                    expHead = expQ.pop_front();
                    addrMatch: assert (pixWrAddr == expHead[39:16]) else begin
                        errCount++;
                        $display("ERR pixWrAddr exp %h got %h", expHead[39:16], pixWrAddr);
                    end
                    dataMatch: assert (pixWrData == expHead[15:0]) else begin
                        errCount++;
                        $display("ERR pixWrData exp %h got %h at addr %h", expHead[15:0],
                                 pixWrData, pixWrAddr);
                    end
                end
            end
            // Grant edge. The DUT snapshots what the shadows hold now.
            if (frameReq && frameAck) begin
                expectClear(shadowBg);
                expectBitRow(`VALUE_ROW_PULSE, shadowFg, shadowBg, shadowPulse);
                expectBitRow(`VALUE_ROW_ACCUM, shadowFg, shadowBg, accumCounter);
                expectModeRow(`MODE_ROW, shadowFg, shadowBg, shadowMode);
            end
            if (frameDone) begin
                // Only what fits in the pixel queue can still be on its way out.
                tailBounded: assert (expQ.size() <= `PIX_FIFO_DEPTH) else begin
                    errCount++;
                    $display("frameDone came with %0d pixel writes still missing",
                             expQ.size());
                end
                powerOnSeen = 1'b1;
            end
            noEarlyReq: assert (powerOnSeen || !frameReq) else begin
                errCount++;
                $display("frameReq raised before the power-on test finished");
            end
        end
    end

    // Random back-pressure, about 70% ready.
    always @(posedge clk) begin
        if (rst_n) begin
            readySeed = lcgNext(readySeed);
            pixWrReady <= ((readySeed >> 16) % 100) < 70;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Handshake rules.
    pixHold: assert property (@(posedge clk) disable iff (!rst_n)
        pixWrValid && !pixWrReady |=> pixWrValid && $stable(pixWrAddr) && $stable(pixWrData))
        else begin
            errCount++;
            $display("ERR pixWrAddr/pixWrData not held under stall, now %h/%h",
                     pixWrAddr, pixWrData);
        end
    reqHold: assert property (@(posedge clk) disable iff (!rst_n)
        frameReq && !frameAck |=> frameReq)
        else begin
            errCount++;
            $display("frameReq dropped before frameAck");
        end
    reqDrop: assert property (@(posedge clk) disable iff (!rst_n)
        frameReq && frameAck |=> !frameReq)
        else begin
            errCount++;
            $display("frameReq still high after the grant");
        end
    donePulse: assert property (@(posedge clk) disable iff (!rst_n) frameDone |=> !frameDone)
        else begin
            errCount++;
            $display("frameDone longer than one cycle");
        end

    // Run limit.
    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the frames did not finish", cycleCount);
        $display("Errors found");
        $finish;
    end

    ///////////////////////////////////////////////////////////////////////
    // Test sequence.
    initial begin
        rst_n        = 1'b0;
        regWrEn      = 1'b0;
        regAddr      = 2'd0;
        regWrData    = 32'd0;
        dataUpdate   = 1'b0;
        pulseCounter = 32'd0;
        accumCounter = 32'h0000_1234;
        frameAck     = 1'b0;
        pixWrReady   = 1'b0;
        shadowMode   = 2'd0;         // Reset values of the register block.
        shadowFg     = `COLOR_WHITE;
        shadowBg     = `COLOR_BLACK;
        shadowPulse  = 32'd0;
        expectClear(`COLOR_RED);     // Power-on screens.
        expectClear(`COLOR_GREEN);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        finishTest("power-on red and green");

        writeReg(2'd0, 32'd0);
        writeReg(2'd1, 32'h0000_001F);
        writeReg(2'd2, 32'h0000_4208);
        latchPulse(32'hA5C3_0F81);
        grantFrame();
        accumCounter <= 32'hFFFF_0000; // Changes after grant, next frame only.
        writeReg(2'd0, 32'd2);
        latchPulse(32'h8000_0001);
        finishTest("frame mode 0");

        grantFrame();
        finishTest("snapshot frame mode 2");

        writeReg(2'd0, 32'd3);
        writeReg(2'd1, 32'h0000_07FF);
        writeReg(2'd2, 32'h0000_F81F);
        latchPulse(32'h5555_AAAA);
        accumCounter <= 32'h0F0F_F0F0;
        grantFrame();
        finishTest("frame mode 3");

        $display("Tests: %0d, pixel writes checked: %0d, errors: %0d", testCount,
                 checkedCount, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/drawSubsystem.sv ====
`include "drawConsts.svh"
`default_nettype none

module drawSubsystem import drawCmdPkg::*, frameBufPkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  regWrEn,
    input  logic [1:0]            regAddr,
    input  logic [31:0]           regWrData,
    input  logic                  dataUpdate,
    input  logic [31:0]           pulseCounter,
    input  logic [31:0]           accumCounter,
    output logic                  frameReq,
    input  logic                  frameAck,
    output logic                  frameDone,
    output logic                  pixWrValid,
    input  logic                  pixWrReady,
    output logic [`FB_ADDR_W-1:0] pixWrAddr,
    output logic [15:0]           pixWrData
);

    drawCfgIf cfgBus ();

    // Sequencer to command queue.
    logic     seqCmdValid;
    logic     seqCmdReady;
    drawCmd_t seqCmd;
    // Command queue to engine.
    logic     engCmdValid;
    logic     engCmdReady;
    drawCmd_t engCmd;
    logic     cmdDone;
    // Engine to pixel queue.
    logic     engPixValid;
    logic     engPixReady;
    pixWr_t   engPix;
    pixWr_t   outPix;

    drawRegs u_drawRegs (
        .clk(clk), .rst_n(rst_n), .regWrEn(regWrEn), .regAddr(regAddr),
        .regWrData(regWrData), .dataUpdate(dataUpdate), .pulseCounter(pulseCounter),
        .cfg(cfgBus.regSide)
    );

    drawSequencer u_drawSequencer (
        .clk(clk), .rst_n(rst_n), .cfg(cfgBus.seqSide), .accumCounter(accumCounter),
        .cmdValid(seqCmdValid), .cmdReady(seqCmdReady), .cmd(seqCmd), .cmdDone(cmdDone),
        .frameReq(frameReq), .frameAck(frameAck), .frameDone(frameDone)
    );

    streamFifo #(.T(drawCmd_t), .DEPTH(`CMD_FIFO_DEPTH)) cmdFifo (
        .clk(clk), .rst_n(rst_n),
        .inValid(seqCmdValid), .inReady(seqCmdReady), .inData(seqCmd),
        .outValid(engCmdValid), .outReady(engCmdReady), .outData(engCmd)
    );

    drawEngine u_drawEngine (
        .clk(clk), .rst_n(rst_n), .cmdValid(engCmdValid), .cmdReady(engCmdReady),
        .cmd(engCmd), .cmdDone(cmdDone),
        .pixValid(engPixValid), .pixReady(engPixReady), .pix(engPix)
    );

    streamFifo #(.T(pixWr_t), .DEPTH(`PIX_FIFO_DEPTH)) pixFifo (
        .clk(clk), .rst_n(rst_n),
        .inValid(engPixValid), .inReady(engPixReady), .inData(engPix),
        .outValid(pixWrValid), .outReady(pixWrReady), .outData(outPix)
    );

    // Split the pixel write onto the memory port.
    assign pixWrAddr = outPix.addr;
    assign pixWrData = outPix.data;

endmodule

`default_nettype wire

// ==== src/drawEngine.sv ====
`include "drawConsts.svh"
`default_nettype none

module drawEngine import drawCmdPkg::*, frameBufPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmdValid,
    output logic     cmdReady,
    input  drawCmd_t cmd,
    output logic     cmdDone,
    output logic     pixValid,
    input  logic     pixReady,
    output pixWr_t   pix
);

    localparam int COL_W  = $clog2(`SCREEN_W);
    localparam int SLOT_W = `SCREEN_W / 4; // Four mode icons across a row.

    drawCmd_t         curCmd;  // Command in progress.
    logic             busy;
    logic [COL_W-1:0] col;
    logic [7:0]       rowIdx;
    logic [7:0]       lastRow;
    logic             lastCol;
    logic             cmdTake;
    logic             pixXfer;
    rgb565_t          pixColor;

    assign cmdReady = !busy;                  // One command at a time.
    assign cmdTake  = cmdValid && cmdReady;
    assign pixValid = busy;
    assign pixXfer  = pixValid && pixReady;
    assign lastCol  = col == COL_W'(`SCREEN_W - 1);
    // CLEAR sweeps every row, the others stay on their own row.
    assign lastRow  = (curCmd.op == OP_CLEAR) ? 8'(`SCREEN_H - 1) : curCmd.row;

    ///////////////////////////////////////////////////////////////////////
    // Pixel colour and address.
    always_comb begin
        case (curCmd.op)
            OP_CLEAR: pixColor = curCmd.fg;
            OP_VALUE: pixColor = curCmd.arg[col] ? curCmd.fg : curCmd.bg;  // Bit k at column k.
            OP_MODE:  pixColor = (32'(col / SLOT_W) == curCmd.arg) ? curCmd.fg : curCmd.bg;
            default:  pixColor = curCmd.bg;
        endcase
    end

    assign pix.addr = fbAddr_t'(32'(rowIdx) * `SCREEN_W + 32'(col)); // Row-major.
    assign pix.data = pixColor;

    ///////////////////////////////////////////////////////////////////////
    // Column and row stepping. Counters hold while the pixel queue is full.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cmdDone <= 1'b0;
            col     <= '0;
            rowIdx  <= 8'd0;
        end else begin
            cmdDone <= 1'b0;
            if (cmdTake) begin
                busy   <= 1'b1;
                col    <= '0;
                rowIdx <= (cmd.op == OP_CLEAR) ? 8'd0 : cmd.row;
            end else if (pixXfer) begin
                if (lastCol) begin
                    col <= '0;
                    if (rowIdx == lastRow) begin
                        busy    <= 1'b0; // Free for the next command.
                        cmdDone <= 1'b1; // Last pixel accepted.
                    end else begin
                        rowIdx <= rowIdx + 8'd1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmdTake) curCmd <= cmd;
    end

    // A taken command keeps the input closed until its completion.
    assert property (@(posedge clk) disable iff (!rst_n)
        cmdTake |=> !cmdReady until cmdDone)
        else $error("drawEngine accepted a command while busy");

endmodule

`default_nettype wire

// ==== src/streamFifo.sv ====
`default_nettype none

module streamFifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic inValid,
    output logic inReady,
    input  T     inData,
    output logic outValid,
    input  logic outReady,
    output T     outData
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count; // Occupancy.
    logic             push;
    logic             pop;

    // Circular increment.
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign inReady  = count != CNT_W'(DEPTH); // Full blocks the writer.
    assign outValid = count != '0;
    assign outData  = mem[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= inData;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= bump(wrPtr);
            if (pop) rdPtr <= bump(rdPtr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Head item holds under back-pressure.
    assert property (@(posedge clk) disable iff (!rst_n)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("streamFifo head changed while stalled");

endmodule

`default_nettype wire

// ==== src/drawSequencer.sv ====
`include "drawConsts.svh"
`default_nettype none

module drawSequencer import drawCmdPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    drawCfgIf.seqSide   cfg,
    input  logic [31:0] accumCounter,
    output logic        cmdValid,
    input  logic        cmdReady,
    output drawCmd_t    cmd,
    input  logic        cmdDone,
    output logic        frameReq,
    input  logic        frameAck,
    output logic        frameDone
);

    // Steps of the sequence. Power-on runs once, then REQ..DRAIN loops.
    typedef enum logic [2:0] {
        ST_POR_RED, ST_POR_GREEN, ST_DRAIN, ST_REQ,
        ST_CLEAR, ST_PULSE, ST_ACCUM, ST_MODE
    } step_e;

    step_e       step;
    logic [2:0]  outstanding; // Taken by the queue, no cmdDone yet.
    logic        cmdXfer;
    logic        slotFree;
    logic        issueStep;
    logic        loadCmd;
    logic        grant;
    drawCmd_t    nextCmd;

    // Frame snapshot.
    logic [1:0]  snapMode;
    rgb565_t     snapFg;
    rgb565_t     snapBg;
    logic [31:0] snapPulse;
    logic [31:0] snapAccum;

    function automatic drawCmd_t mkCmd(input drawOp_e op, input int row, input rgb565_t fg,
                                       input rgb565_t bg, input logic [31:0] arg);
        drawCmd_t c;
        c.op  = op;
        c.row = 8'(row);
        c.fg  = fg;
        c.bg  = bg;
        c.arg = arg;
        return c;
    endfunction

    assign cmdXfer  = cmdValid && cmdReady;
    assign slotFree = !cmdValid || cmdReady; // Output register empty or leaving now.
    assign loadCmd  = issueStep && slotFree;
    assign grant    = (step == ST_REQ) && frameReq && frameAck;

    ///////////////////////////////////////////////////////////////////////
    // Command for the current step.
    always_comb begin
        issueStep = 1'b1;
        nextCmd   = mkCmd(OP_CLEAR, 0, snapBg, snapBg, 32'd0);
        case (step)
            ST_POR_RED:   nextCmd = mkCmd(OP_CLEAR, 0, `COLOR_RED, `COLOR_RED, 32'd0);
            ST_POR_GREEN: nextCmd = mkCmd(OP_CLEAR, 0, `COLOR_GREEN, `COLOR_GREEN, 32'd0);
            ST_CLEAR:     nextCmd = mkCmd(OP_CLEAR, 0, snapBg, snapBg, 32'd0); // Fill in bg.
            ST_PULSE:     nextCmd = mkCmd(OP_VALUE, `VALUE_ROW_PULSE, snapFg, snapBg, snapPulse);
            ST_ACCUM:     nextCmd = mkCmd(OP_VALUE, `VALUE_ROW_ACCUM, snapFg, snapBg, snapAccum);
            ST_MODE:      nextCmd = mkCmd(OP_MODE, `MODE_ROW, snapFg, snapBg, 32'(snapMode));
            default:      issueStep = 1'b0; // Waiting steps issue nothing.
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // Step machine and handshakes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step        <= ST_POR_RED;
            cmdValid    <= 1'b0;
            outstanding <= 3'd0;
            frameReq    <= 1'b0;
            frameDone   <= 1'b0;
        end else begin
            frameDone   <= 1'b0;                                     // Single-cycle pulse.
            outstanding <= outstanding + 3'(cmdXfer) - 3'(cmdDone);
            if (loadCmd) begin
                cmdValid <= 1'b1;
            end else if (cmdXfer) begin
                cmdValid <= 1'b0;
            end
            case (step)
                ST_POR_RED:   if (loadCmd) step <= ST_POR_GREEN;
                ST_POR_GREEN: if (loadCmd) step <= ST_DRAIN;
                ST_DRAIN: begin
                    // Last completion of the phase, nothing left to issue.
                    if (!cmdValid && cmdDone && outstanding == 3'd1) begin
                        frameDone <= 1'b1;
                        step      <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (grant) begin
                        frameReq <= 1'b0;
                        step     <= ST_CLEAR;
                    end else begin
                        frameReq <= 1'b1; // Rises after frameDone, holds until ack.
                    end
                end
                ST_CLEAR:     if (loadCmd) step <= ST_PULSE;
                ST_PULSE:     if (loadCmd) step <= ST_ACCUM;
                ST_ACCUM:     if (loadCmd) step <= ST_MODE;
                ST_MODE:      if (loadCmd) step <= ST_DRAIN;
                default:      step <= ST_POR_RED;
            endcase
        end
    end

    // Command payload and frame snapshot.
    always_ff @(posedge clk) begin
        if (loadCmd) begin
            cmd <= nextCmd;
        end
        if (grant) begin
            snapMode  <= cfg.mode;
            snapFg    <= cfg.fgColor;
            snapBg    <= cfg.bgColor;
            snapPulse <= cfg.pulseCount;
            snapAccum <= accumCounter;
        end
    end

    // Each completion from the engine matches a command taken earlier.
    assert property (@(posedge clk) disable iff (!rst_n) cmdDone |-> outstanding != 3'd0)
        else $error("cmdDone with no command outstanding");

endmodule

`default_nettype wire

// ==== src/drawRegs.sv ====
`include "drawConsts.svh"
`default_nettype none

module drawRegs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        regWrEn,
    input  logic [1:0]  regAddr,
    input  logic [31:0] regWrData,
    input  logic        dataUpdate,
    input  logic [31:0] pulseCounter,
    drawCfgIf.regSide   cfg
);

    // Register map.
    localparam logic [1:0] ADDR_MODE = 2'd0;
    localparam logic [1:0] ADDR_FG   = 2'd1;
    localparam logic [1:0] ADDR_BG   = 2'd2;

    // Mode and colours, written one at a time.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.mode    <= 2'd0;
            cfg.fgColor <= `COLOR_WHITE;
            cfg.bgColor <= `COLOR_BLACK;
        end else if (regWrEn) begin
            case (regAddr)
                ADDR_MODE: cfg.mode    <= regWrData[1:0];  // Icon index only.
                ADDR_FG:   cfg.fgColor <= regWrData[15:0]; // Low half is RGB565.
                ADDR_BG:   cfg.bgColor <= regWrData[15:0];
                default:   ;                               // Address 3 reads as nothing.
            endcase
        end
    end

    // Pulse counter latch, new value on each update strobe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.pulseCount <= 32'd0;
        end else if (dataUpdate) begin
            cfg.pulseCount <= pulseCounter;
        end
    end

endmodule

`default_nettype wire

// ==== src/drawCfgIf.sv ====
`default_nettype none

// Configuration snapshot from the register block to the sequencer.
// Plain levels with no handshake.
interface drawCfgIf import drawCmdPkg::*; ();

    logic [1:0]  mode;       // Active mode icon, 0..3.
    rgb565_t     fgColor;    // Foreground for value and mode rows.
    rgb565_t     bgColor;    // Clear colour and unset cells.
    logic [31:0] pulseCount; // Last latched pulse counter.

    // Register side owns the values.
    modport regSide (
        output mode,
        output fgColor,
        output bgColor,
        output pulseCount
    );

    // Sequencer samples them at frame grant.
    modport seqSide (
        input mode,
        input fgColor,
        input bgColor,
        input pulseCount
    );

endinterface

`default_nettype wire

// ==== src/frameBufPkg.sv ====
`include "drawConsts.svh"
`default_nettype none

package frameBufPkg;

    import drawCmdPkg::*;

    // Linear pixel address, row * SCREEN_W + column.
    typedef logic [`FB_ADDR_W-1:0] fbAddr_t;

    // One write into the frame buffer.
    typedef struct packed {
        fbAddr_t addr;
        rgb565_t data;
    } pixWr_t;

endpackage

`default_nettype wire

// ==== src/drawCmdPkg.sv ====
`default_nettype none

package drawCmdPkg;

    // One pixel colour, R[15:11] G[10:5] B[4:0].
    typedef logic [15:0] rgb565_t;

    // Operations the draw engine knows.
    typedef enum logic [1:0] {
        OP_CLEAR = 2'd0, // Whole screen in fg.
        OP_VALUE = 2'd1, // 32 bit-cells on one row.
        OP_MODE  = 2'd2  // Four icon slots, active slot in fg.
    } drawOp_e;

    // One drawing command as it travels through the command queue.
    typedef struct packed {
        drawOp_e     op;
        logic [7:0]  row; // Target row. Ignored by CLEAR.
        rgb565_t     fg;
        rgb565_t     bg;
        logic [31:0] arg; // Value bits or active mode index.
    } drawCmd_t;

endpackage

`default_nettype wire

// ==== src/drawConsts.svh ====
`ifndef DRAW_CONSTS_SVH
`define DRAW_CONSTS_SVH

// Panel geometry in pixels.
`define SCREEN_W 32
`define SCREEN_H 16

// Linear frame-buffer address width.
`define FB_ADDR_W 24

// Power-on test colours in RGB565.
`define COLOR_RED   16'hF800
`define COLOR_GREEN 16'h07E0
`define COLOR_WHITE 16'hFFFF // Foreground after reset.
`define COLOR_BLACK 16'h0000 // Background after reset.

// Queue depths in entries.
`define CMD_FIFO_DEPTH 2
`define PIX_FIFO_DEPTH 4

// Frame layout rows.
`define VALUE_ROW_PULSE 2
`define VALUE_ROW_ACCUM 5
`define MODE_ROW        9

`endif
